//--- logic/bp_consts.svh
// branch predictor sizes
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// slots per fetch block
`define FETCH_NUM 4

// slots per cache block as a power of two
`define CBLK_SLOTS 16

// bimodal bank index width for 256 counters
`define BANK_IDX 8

// btb index width
`define BTB_IDX 6

`define HIST_LEN 32   // global history bits

`define FTQ_DEPTH 4   // queue entries

`define RST_PC 64'h1000

`endif

//--- logic/bp_pkg.sv
// branch predictor types
package bp_pkg;

    // commit side update kinds
    typedef enum logic [1:0] {
        upd_none,
        upd_redirect,
        upd_reinforce
    } upd_kind_e;

    // slots in one fetch block from 1 to FETCH_NUM
    typedef logic [2:0] slot_cnt_t;

endpackage

//--- logic/pc_gen.sv
// fetch pc and block cut
`timescale 1ns/1ps
`include "bp_consts.svh"

module pc_gen import bp_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redir,
    input  logic                        ready,
    input  logic [63:0]                 unpc,
    input  logic [`FETCH_NUM-1:0]       cnt_top,
    input  logic [`FETCH_NUM-1:0][63:0] tgt,
    output logic [63:0]                 pc,
    output logic [6:0]                  id,
    output slot_cnt_t                   blk_num,
    output logic                        blk_br,
    output logic [63:0]                 blk_target
);
    localparam int OFF_W = $clog2(`CBLK_SLOTS);

    logic             hit;
    logic [OFF_W-1:0] off;   // slot offset inside cache block
    logic [OFF_W:0]   left;  // slots up to the boundary
    logic [63:0]      npc;

    always_comb begin
        hit        = 1'b0;
        blk_num    = slot_cnt_t'(`FETCH_NUM);
        blk_br     = 1'b0;
        blk_target = 64'd0;
        for (int i = 0; i < `FETCH_NUM; i++) begin
            if (!hit && cnt_top[i]) begin  // first predicted taken slot
                hit        = 1'b1;
                blk_num    = slot_cnt_t'(i + 1);
                blk_br     = 1'b1;
                blk_target = tgt[i];
            end
        end

        // block may not run past the cache block
        off  = pc[OFF_W:1];
        left = (OFF_W + 1)'(`CBLK_SLOTS) - {1'b0, off};
        if (off != '0 && (OFF_W + 1)'(blk_num) > left) begin
            blk_num    = slot_cnt_t'(left);
            blk_br     = 1'b0;  // taken slot falls in the next line
            blk_target = 64'd0;
        end
    end

    assign npc = blk_br ? blk_target : pc + 64'({blk_num, 1'b0});

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RST_PC;
        end else if (redir) begin
            pc <= unpc;  // correct path from commit
        end else if (ready) begin
            pc <= npc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redir) begin
            id <= 7'd0;
        end else if (ready) begin
            id <= id + 7'd1;  // one per accepted block
        end
    end

endmodule

//--- logic/ghist_track.sv
// global history register
`timescale 1ns/1ps
`include "bp_consts.svh"

module ghist_track import bp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 redir,
    input  logic                 ready,
    input  slot_cnt_t            blk_num,
    input  logic                 blk_br,
    input  logic [`HIST_LEN-1:0] ugh,
    input  logic                 upat_top,
    output logic [`HIST_LEN-1:0] gh
);
    upd_kind_e            kind;
    logic [`HIST_LEN-1:0] shifted;   // history after this block
    logic [`HIST_LEN-1:0] restored;  // history handed back by commit

    assign kind = redir ? upd_redirect : upd_none;

    // one bit per predicted slot with a taken branch in bit 0
    assign shifted = (gh << blk_num) | {{(`HIST_LEN - 1){1'b0}}, blk_br};

    // low bit holds the actual outcome of the resolved branch
    assign restored = {ugh[`HIST_LEN-1:1], ~upat_top};

    always_ff @(posedge clk) begin
        if (rst) begin
            gh <= '0;
        end else begin
            case (kind)
                upd_redirect: begin
                    gh <= restored;
                end
                default: begin
                    if (ready) begin
                        gh <= shifted;  // block accepted by the queue
                    end
                end
            endcase
        end
    end

    // a zero block size would stall the history
    a_num_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        blk_num != '0
    ) else $error("ghist_track: block slot count is zero");

endmodule

//--- logic/bimodal_btb.sv
// bimodal counters and btb
`timescale 1ns/1ps
`include "bp_consts.svh"

module bimodal_btb import bp_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [63:0]                 pc,
    input  logic                        redir,
    input  logic                        reinf,
    input  logic [63:0]                 upc,
    input  logic [63:0]                 unpc,
    input  logic [1:0]                  upat,
    input  logic                        ubank,
    output logic [`FETCH_NUM-1:0]       cnt_top,
    output logic [`FETCH_NUM-1:0][63:0] tgt
);
    localparam int BANK_N = 1 << `BANK_IDX;
    localparam int BTB_N  = 1 << `BTB_IDX;

    logic [1:0]           bank [BANK_N];  // 2-bit saturating counters
    logic [63:0]          btb  [BTB_N];
    upd_kind_e            kind;
    logic [1:0]           npat;           // updated counter value
    logic                 bank_wena;
    logic [`BANK_IDX-1:0] bank_waddr;
    logic [1:0]           bank_wvalue;
    logic                 btb_wena;
    logic [`BTB_IDX-1:0]  btb_waddr;
    logic [63:0]          btb_wvalue;
    logic [`BANK_IDX-1:0] bank_raddr [`FETCH_NUM];
    logic [`BTB_IDX-1:0]  btb_raddr  [`FETCH_NUM];

    always_comb begin
        if (redir) begin
            kind = upd_redirect;
        end else if (reinf) begin
            kind = upd_reinforce;
        end else begin
            kind = upd_none;
        end
    end

    // saturated cases never arrive from commit
    always_comb begin
        case (kind)
            upd_redirect:  npat = upat[1] ? upat - 2'd1 : upat + 2'd1;
            upd_reinforce: npat = upat[1] ? upat + 2'd1 : upat - 2'd1;
            default:       npat = upat;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_wena <= 1'b0;
            btb_wena  <= 1'b0;
        end else begin
            bank_wena <= kind != upd_none;
            btb_wena  <= kind == upd_redirect && !upat[1] && ubank;  // missed taken branch
        end
    end

    always_ff @(posedge clk) begin
        bank_waddr  <= upc[`BANK_IDX:1];
        bank_wvalue <= npat;
        btb_waddr   <= upc[`BTB_IDX:1];
        btb_wvalue  <= unpc;
    end

    // whole bank cleared in one edge under reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BANK_N; i++) begin
                bank[i] <= 2'd0;
            end
        end else if (bank_wena) begin
            bank[bank_waddr] <= bank_wvalue;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_wena) begin
            btb[btb_waddr] <= btb_wvalue;
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_NUM; i++) begin
            bank_raddr[i] = pc[`BANK_IDX:1] + `BANK_IDX'(i);  // slot pc + i
            btb_raddr[i]  = pc[`BTB_IDX:1] + `BTB_IDX'(i);
            cnt_top[i]    = bank[bank_raddr[i]][1];
            tgt[i]        = btb[btb_raddr[i]];
        end
    end

    // commit sends at most one update kind per cycle
    a_one_update: assert property (
        @(posedge clk) disable iff (rst)
        !(redir && reinf)
    ) else $error("bimodal_btb: redirect and reinforce in the same cycle");

endmodule

//--- logic/fetch_target_queue.sv
// fetch target queue
`timescale 1ns/1ps
`include "bp_consts.svh"

module fetch_target_queue import bp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 redir,
    input  logic [63:0]          push_pc,
    input  slot_cnt_t            push_num,
    input  logic                 push_br,
    input  logic [63:0]          push_target,
    input  logic [6:0]           push_id,
    input  logic [`HIST_LEN-1:0] push_gh,
    input  logic                 take,
    output logic                 ready,
    output logic                 ftq_valid,
    output logic [63:0]          ftq_pc,
    output slot_cnt_t            ftq_num,
    output logic                 ftq_br,
    output logic [63:0]          ftq_target,
    output logic [7:0]           ftq_id,
    output logic [`HIST_LEN-1:0] ftq_gh
);
    localparam int PTR_W = $clog2(`FTQ_DEPTH);
    localparam int CNT_W = $clog2(`FTQ_DEPTH + 1);

    logic [63:0]          q_pc     [`FTQ_DEPTH];
    slot_cnt_t            q_num    [`FTQ_DEPTH];
    logic                 q_br     [`FTQ_DEPTH];
    logic [63:0]          q_target [`FTQ_DEPTH];
    logic [6:0]           q_id     [`FTQ_DEPTH];
    logic [`HIST_LEN-1:0] q_gh     [`FTQ_DEPTH];
    logic [PTR_W-1:0]     wptr;
    logic [PTR_W-1:0]     rptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;

    assign do_pop  = take && ftq_valid;
    assign ready   = (count != CNT_W'(`FTQ_DEPTH)) || do_pop;  // pop frees a slot this edge
    assign do_push = ready;

    always_ff @(posedge clk) begin
        if (rst || redir) begin  // flush on wrong path
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= (wptr == PTR_W'(`FTQ_DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= (rptr == PTR_W'(`FTQ_DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            q_pc[wptr]     <= push_pc;
            q_num[wptr]    <= push_num;
            q_br[wptr]     <= push_br;
            q_target[wptr] <= push_target;
            q_id[wptr]     <= push_id;
            q_gh[wptr]     <= push_gh;
        end
    end

    assign ftq_valid  = count != '0;
    assign ftq_pc     = q_pc[rptr];
    assign ftq_num    = q_num[rptr];
    assign ftq_br     = q_br[rptr];
    assign ftq_target = q_target[rptr];
    assign ftq_id     = {1'b1, q_id[rptr]};  // top bit marks a queue id
    assign ftq_gh     = q_gh[rptr];

    // fetch side only pops what it can see
    a_no_empty_take: assert property (
        @(posedge clk) disable iff (rst)
        take |-> ftq_valid
    ) else $error("fetch_target_queue: take on empty queue");

endmodule

//--- logic/frontend_top.sv
// prediction front end
`timescale 1ns/1ps
`include "bp_consts.svh"

module frontend_top import bp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 redir,
    input  logic                 reinf,
    input  logic [63:0]          upc,
    input  logic [63:0]          unpc,
    input  logic [1:0]           upat,
    input  logic [`HIST_LEN-1:0] ugh,
    input  logic                 ubank,
    input  logic                 take,
    output logic                 ftq_valid,
    output logic [63:0]          ftq_pc,
    output slot_cnt_t            ftq_num,
    output logic                 ftq_br,
    output logic [63:0]          ftq_target,
    output logic [7:0]           ftq_id,
    output logic [`HIST_LEN-1:0] ftq_gh
);
    logic [63:0]                 pc;
    logic [6:0]                  id;
    slot_cnt_t                   blk_num;
    logic                        blk_br;
    logic [63:0]                 blk_target;
    logic [`FETCH_NUM-1:0]       cnt_top;
    logic [`FETCH_NUM-1:0][63:0] tgt;
    logic [`HIST_LEN-1:0]        gh;
    logic                        ready;  // queue has room

    pc_gen pc_gen_inst (
        .clk(clk), .rst(rst), .redir(redir), .ready(ready), .unpc(unpc),
        .cnt_top(cnt_top), .tgt(tgt), .pc(pc), .id(id),
        .blk_num(blk_num), .blk_br(blk_br), .blk_target(blk_target)
    );

    ghist_track ghist_track_inst (
        .clk(clk), .rst(rst), .redir(redir), .ready(ready),
        .blk_num(blk_num), .blk_br(blk_br), .ugh(ugh), .upat_top(upat[1]), .gh(gh)
    );

    bimodal_btb bimodal_btb_inst (
        .clk(clk), .rst(rst), .pc(pc), .redir(redir), .reinf(reinf),
        .upc(upc), .unpc(unpc), .upat(upat), .ubank(ubank),
        .cnt_top(cnt_top), .tgt(tgt)
    );

    fetch_target_queue fetch_target_queue_inst (
        .clk(clk), .rst(rst), .redir(redir),
        .push_pc(pc), .push_num(blk_num), .push_br(blk_br),
        .push_target(blk_target), .push_id(id), .push_gh(gh),
        .take(take), .ready(ready), .ftq_valid(ftq_valid), .ftq_pc(ftq_pc),
        .ftq_num(ftq_num), .ftq_br(ftq_br), .ftq_target(ftq_target),
        .ftq_id(ftq_id), .ftq_gh(ftq_gh)
    );

endmodule

//--- bench/frontend_tb.sv
// prediction front end testbench
`timescale 1ns/1ps
`include "bp_consts.svh"

module frontend_tb import bp_pkg::*; ();
    localparam int ROWS_MAX    = 64;
    localparam int RAND_REDIRS = 6;
    localparam int OFF_W       = $clog2(`CBLK_SLOTS);

    logic clk = 1'b0;
    logic rst, redir, reinf, ubank, take;
    logic [63:0] upc, unpc;
    logic [1:0] upat;
    logic [`HIST_LEN-1:0] ugh;
    logic ftq_valid, ftq_br;
    logic [63:0] ftq_pc, ftq_target;
    slot_cnt_t ftq_num;
    logic [7:0] ftq_id;
    logic [`HIST_LEN-1:0] ftq_gh;

    // step table
    upd_kind_e t_kind [ROWS_MAX];
    logic t_chk [ROWS_MAX];     // wait for head, compare, then take
    logic [63:0] t_upc [ROWS_MAX];
    logic [63:0] t_unpc [ROWS_MAX];
    logic [1:0] t_upat [ROWS_MAX];
    logic [`HIST_LEN-1:0] t_ugh [ROWS_MAX];
    logic t_ubank [ROWS_MAX];
    logic t_fix [ROWS_MAX];            // directed head values given
    logic [63:0] t_exp_pc [ROWS_MAX];
    int t_exp_num [ROWS_MAX];
    logic t_exp_br [ROWS_MAX];
    logic [63:0] t_exp_tgt [ROWS_MAX];
    logic [6:0] t_exp_id [ROWS_MAX];   // low id bits
    int nrows = 0;

    // reference model state
    logic [1:0] cnt [1 << `BANK_IDX];
    logic [63:0] btb [1 << `BTB_IDX];
    logic [63:0] m_pc = `RST_PC;
    logic [`HIST_LEN-1:0] m_gh = '0;
    logic [6:0] m_id = 7'd0;
    logic pend_cnt = 1'b0;       // redirect write not yet seen by the first block
    logic pend_btb = 1'b0;
    logic [`BANK_IDX-1:0] pend_idx;
    logic [1:0] pend_val;
    logic [`BTB_IDX-1:0] pend_bidx;
    logic [63:0] pend_tgt;
    int e_num;
    logic e_br;
    logic [63:0] e_tgt;
    integer seed = 32'hc493_25bc;
    int cycles = 0;
    int limit = 40 * ROWS_MAX + 8;

    frontend_top frontend_top_inst (
        .clk(clk), .rst(rst), .redir(redir), .reinf(reinf), .upc(upc), .unpc(unpc),
        .upat(upat), .ugh(ugh), .ubank(ubank), .take(take), .ftq_valid(ftq_valid),
        .ftq_pc(ftq_pc), .ftq_num(ftq_num), .ftq_br(ftq_br), .ftq_target(ftq_target),
        .ftq_id(ftq_id), .ftq_gh(ftq_gh)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run hung waiting for a queue head");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    task automatic add_row(input upd_kind_e k, input logic c, input logic [63:0] pc_u,
                           input logic [63:0] npc_u, input logic [1:0] pat,
                           input logic [`HIST_LEN-1:0] h, input logic bank,
                           input logic fix, input logic [63:0] xp, input int xn,
                           input logic xb, input logic [63:0] xt, input logic [6:0] xi);
        t_kind[nrows] = k;
        t_chk[nrows] = c;
        t_upc[nrows] = pc_u;
        t_unpc[nrows] = npc_u;
        t_upat[nrows] = pat;
        t_ugh[nrows] = h;
        t_ubank[nrows] = bank;
        t_fix[nrows] = fix;
        t_exp_pc[nrows] = xp;
        t_exp_num[nrows] = xn;
        t_exp_br[nrows] = xb;
        t_exp_tgt[nrows] = xt;
        t_exp_id[nrows] = xi;
        nrows++;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // up on a redirect of a not-taken or a reinforce of a taken pattern
    function automatic logic [1:0] next_pat(input upd_kind_e k, input logic [1:0] p);
        logic up;
        up = (k == upd_redirect && !p[1]) || (k == upd_reinforce && p[1]);
        return up ? p + 2'd1 : p - 2'd1;
    endfunction

    task automatic apply_pending();
        if (pend_cnt) cnt[pend_idx] = pend_val;
        if (pend_btb) btb[pend_bidx] = pend_tgt;
        pend_cnt = 1'b0;
        pend_btb = 1'b0;
    endtask

    task automatic predict_block();
        logic hit;
        int off;
        int left;
        hit = 1'b0;
        e_num = `FETCH_NUM;
        e_br = 1'b0;
        e_tgt = 64'd0;
        for (int i = 0; i < `FETCH_NUM; i++) begin
            if (!hit && cnt[m_pc[`BANK_IDX:1] + `BANK_IDX'(i)][1]) begin
                hit = 1'b1;
                e_num = i + 1;
                e_br = 1'b1;
                e_tgt = btb[m_pc[`BTB_IDX:1] + `BTB_IDX'(i)];
            end
        end
        off = int'(m_pc[OFF_W:1]);
        left = `CBLK_SLOTS - off;
        if (off != 0 && e_num > left) begin  // cut at cache block end
            e_num = left;
            e_br = 1'b0;
            e_tgt = 64'd0;
        end
    endtask

    task automatic check_head(input int r);
        while (!ftq_valid) begin
            @(posedge clk);
            #2;
        end
        predict_block();
        if (t_fix[r]) begin
            check_val("ftq_pc", ftq_pc, t_exp_pc[r]);
            check_val("ftq_num", 64'(ftq_num), 64'(t_exp_num[r]));
            check_val("ftq_br", 64'(ftq_br), 64'(t_exp_br[r]));
            check_val("ftq_target", ftq_target, t_exp_tgt[r]);
            check_val("ftq_id", 64'(ftq_id), 64'({1'b1, t_exp_id[r]}));
        end
        check_val("ftq_pc", ftq_pc, m_pc);
        check_val("ftq_num", 64'(ftq_num), 64'(e_num));
        check_val("ftq_br", 64'(ftq_br), 64'(e_br));
        check_val("ftq_target", ftq_target, e_tgt);
        check_val("ftq_id", 64'(ftq_id), 64'({1'b1, m_id}));
        check_val("ftq_gh", 64'(ftq_gh), 64'(m_gh));
        apply_pending();
        m_gh = (m_gh << e_num) | `HIST_LEN'(e_br);
        m_pc = e_br ? e_tgt : m_pc + 64'(2 * e_num);
        m_id++;
        take = 1'b1;
        @(posedge clk);
        #2;
        take = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        redir = 1'b0;
        reinf = 1'b0;
        take = 1'b0;
        ubank = 1'b0;
        upc = 64'd0;
        unpc = 64'd0;
        upat = 2'd0;
        ugh = '0;
        for (int i = 0; i < (1 << `BANK_IDX); i++) cnt[i] = 2'd0;

        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1000, 4, 0, 0, 0);  // sequential blocks
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1008, 4, 0, 0, 1);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1010, 4, 0, 0, 2);
        add_row(upd_redirect, 0, 64'h2000, 64'h101a, 0, 32'hf0, 0, 0, 0, 0, 0, 0, 0);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h101a, 3, 0, 0, 0);  // cut to 3 slots
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1020, 4, 0, 0, 1);
        // train taken
        add_row(upd_redirect, 0, 64'h1024, 64'h1100, 0, 32'h0, 1, 0, 0, 0, 0, 0, 0);
        add_row(upd_redirect, 0, 64'h1024, 64'h1100, 1, 32'h0, 1, 0, 0, 0, 0, 0, 0);
        add_row(upd_redirect, 0, 64'h3000, 64'h1020, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1020, 3, 1, 64'h1100, 0);  // taken slot 2
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1100, 4, 0, 0, 1);
        add_row(upd_reinforce, 0, 64'h1024, 0, 2, 32'h0, 1, 0, 0, 0, 0, 0, 0);
        add_row(upd_redirect, 0, 64'h3000, 64'h1020, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1020, 3, 1, 64'h1100, 0);
        // back to not taken
        add_row(upd_reinforce, 0, 64'h1024, 0, 1, 32'h0, 1, 0, 0, 0, 0, 0, 0);
        add_row(upd_redirect, 0, 64'h3000, 64'h1020, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1020, 4, 0, 0, 0);
        for (int i = 0; i < 4; i++) begin
            add_row(upd_none, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);  // queue fills
        end
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1028, 4, 0, 0, 1);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1030, 4, 0, 0, 2);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1038, 4, 0, 0, 3);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1040, 4, 0, 0, 4);
        add_row(upd_none, 1, 0, 0, 0, 0, 0, 1, 64'h1048, 4, 0, 0, 5);  // held while full
        for (int k = 0; k < RAND_REDIRS; k++) begin
            add_row(upd_redirect, 0, 64'h1000 + 64'($random(seed) & 32'hfe),
                    64'h1000 + 64'($random(seed) & 32'hfe),
                    2'(($random(seed) & 32'h7fff_ffff) % 3), $random(seed), 1,
                    0, 0, 0, 0, 0, 0);
            add_row(upd_none, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
            add_row(upd_none, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        end
        limit = 40 * nrows + 8 + 4;

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int r = 0; r < nrows; r++) begin
            if (t_kind[r] != upd_none) begin
                apply_pending();
                if (t_kind[r] == upd_redirect) begin
                    pend_cnt = 1'b1;
                    pend_idx = t_upc[r][`BANK_IDX:1];
                    pend_val = next_pat(upd_redirect, t_upat[r]);
                    pend_btb = !t_upat[r][1] && t_ubank[r];
                    pend_bidx = t_upc[r][`BTB_IDX:1];
                    pend_tgt = t_unpc[r];
                    m_pc = t_unpc[r];
                    m_gh = {t_ugh[r][`HIST_LEN-1:1], ~t_upat[r][1]};
                    m_id = 7'd0;
                end else begin
                    cnt[t_upc[r][`BANK_IDX:1]] = next_pat(upd_reinforce, t_upat[r]);
                end
                redir = t_kind[r] == upd_redirect;
                reinf = t_kind[r] == upd_reinforce;
                upc = t_upc[r];
                unpc = t_unpc[r];
                upat = t_upat[r];
                ugh = t_ugh[r];
                ubank = t_ubank[r];
                @(posedge clk);
                #2;
                redir = 1'b0;
                reinf = 1'b0;
            end else if (!t_chk[r]) begin
                @(posedge clk);
                #2;
            end
            if (t_chk[r]) check_head(r);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/bp_pkg.sv
logic/pc_gen.sv
logic/ghist_track.sv
logic/bimodal_btb.sv
logic/fetch_target_queue.sv
logic/frontend_top.sv
bench/frontend_tb.sv

//--- Makefile
# Verilator build for the prediction front end

VERILATOR ?= verilator
TOP       ?= frontend_tb
FLIST     ?= project.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)

run: compile
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
